// ==== verilog/bg_types_pkg.sv ====
`default_nettype none

package bg_types_pkg;

	typedef logic [7:0]  scroll_t;   // SCX / SCY register value
	typedef logic [7:0]  coord_t;    // Line or pixel coordinate
	typedef logic [4:0]  tile_idx_t; // Row or column in the 32x32 map
	typedef logic [2:0]  fine_t;     // Pixel or row inside a tile
	typedef logic [12:0] vaddr_t;    // 8 KB video memory
	typedef logic [7:0]  vdata_t;
	typedef logic [1:0]  pix_t;      // Colour index before palette

	// Each read step spends one cycle on rd and one on cap
	typedef enum logic [2:0] {
		IDLE,
		MAP,
		DATA_LO,
		DATA_HI,
		WAIT,
		DONE
	} fetch_step_t;

endpackage

`default_nettype wire

// ==== verilog/bg_map_pkg.sv ====
`default_nettype none

package bg_map_pkg;

	// Tile maps, selected by map_sel
	localparam bg_types_pkg::vaddr_t MAP0_BASE = 13'h1800;
	localparam bg_types_pkg::vaddr_t MAP1_BASE = 13'h1C00;

	// Tile data, unsigned from the bottom or signed around the middle
	localparam bg_types_pkg::vaddr_t DATA_UNSIGNED_BASE = 13'h0000;
	localparam bg_types_pkg::vaddr_t DATA_SIGNED_BASE   = 13'h1000;

	localparam bg_types_pkg::vaddr_t MAP_ROW_STRIDE = 13'd32; // Entries per map row
	localparam bg_types_pkg::vaddr_t TILE_BYTES     = 13'd16; // Two planes of 8 rows

	localparam int LINE_PIXELS    = 160;
	localparam int TILES_PER_LINE = 21; // Extra tile covers fine scroll

endpackage

`default_nettype wire

// ==== verilog/bg_fetch_if.sv ====
`default_nettype none

interface bg_fetch_if;

	bg_types_pkg::fetch_step_t step;
	bg_types_pkg::tile_idx_t   tile_col; // Fetch column before scroll
	logic                      rd;
	logic                      cap;      // Read data valid, one cycle after rd
	logic                      push;     // Parallel load of the shifter
	logic                      shift;

	modport ctrl (
		output step, tile_col, rd, cap, push, shift
	);

	modport addr (
		input step, tile_col, rd
	);

	modport data (
		input step, cap, push, shift
	);

endinterface

`default_nettype wire

// ==== verilog/bg_fetch_ctrl.sv ====
`default_nettype none

module bg_fetch_ctrl (
	input  logic                  clkpipe,
	input  logic                  rst_n,
	input  logic                  line_start,
	input  bg_types_pkg::scroll_t scx,
	bg_fetch_if.ctrl              fetch,
	output logic                  pixel_valid,
	output logic                  line_done
);

	bg_types_pkg::fetch_step_t step;
	bg_types_pkg::tile_idx_t   tile_col;
	bg_types_pkg::tile_idx_t   tile_cnt;  // Tiles pushed this line
	bg_types_pkg::fine_t       disc_cnt;  // Fine-scroll pixels still to drop
	bg_types_pkg::coord_t      pix_cnt;
	logic [3:0]                sh_cnt;    // Pixels left in the shifter
	logic                      phase;     // 0 = rd cycle, 1 = cap cycle
	logic                      tile_full;
	logic                      reading;
	logic                      shift;
	logic                      push;
	logic                      last_pix;

	assign reading = (step == bg_types_pkg::MAP) || (step == bg_types_pkg::DATA_LO) ||
		(step == bg_types_pkg::DATA_HI);
	assign shift = (step != bg_types_pkg::IDLE) && (sh_cnt != 4'd0);
	// Load while the last pixel leaves so the stream has no gap
	assign push = tile_full && ((sh_cnt == 4'd0) || (sh_cnt == 4'd1 && shift));
	assign pixel_valid = shift && (disc_cnt == 3'd0);
	assign last_pix = pixel_valid && (pix_cnt == 8'(bg_map_pkg::LINE_PIXELS - 1));

	assign fetch.step = step;
	assign fetch.tile_col = tile_col;
	assign fetch.rd = reading && !phase;
	assign fetch.cap = reading && phase;
	assign fetch.push = push;
	assign fetch.shift = shift;

	always_ff @(posedge clkpipe) begin
		if (!rst_n) begin
			step <= bg_types_pkg::IDLE;
			phase <= 1'b0;
			tile_full <= 1'b0;
			tile_col <= '0;
			tile_cnt <= '0;
			disc_cnt <= '0;
			pix_cnt <= '0;
			sh_cnt <= '0;
			line_done <= 1'b0;
		end else begin
			line_done <= last_pix;
			if (step == bg_types_pkg::IDLE) begin
				if (line_start) begin
					step <= bg_types_pkg::MAP;
					phase <= 1'b0;
					tile_full <= 1'b0;
					tile_col <= '0;
					tile_cnt <= '0;
					disc_cnt <= scx[2:0];
					pix_cnt <= '0;
					sh_cnt <= '0;
				end
			end else if (last_pix) begin
				step <= bg_types_pkg::IDLE; // May cut short the spare tile fetch
			end else begin
				if (reading)
					phase <= !phase;
				case (step)
					bg_types_pkg::MAP: if (phase) step <= bg_types_pkg::DATA_LO;
					bg_types_pkg::DATA_LO: if (phase) step <= bg_types_pkg::DATA_HI;
					bg_types_pkg::DATA_HI: begin
						if (phase) begin
							step <= bg_types_pkg::WAIT;
							tile_full <= 1'b1;
						end
					end
					bg_types_pkg::WAIT: begin
						if (push) begin
							tile_full <= 1'b0;
							if (tile_cnt == 5'(bg_map_pkg::TILES_PER_LINE - 1))
								step <= bg_types_pkg::DONE;
							else
								step <= bg_types_pkg::MAP;
						end
					end
					default: ;
				endcase
				sh_cnt <= push ? 4'd8 : sh_cnt - {3'b000, shift};
				if (push) begin
					tile_cnt <= tile_cnt + 5'd1;
					tile_col <= tile_col + 5'd1; // Wraps at 32
				end
				if (shift && disc_cnt != 3'd0)
					disc_cnt <= disc_cnt - 3'd1;
				if (pixel_valid)
					pix_cnt <= pix_cnt + 8'd1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== verilog/bg_scroll_add.sv ====
`default_nettype none

module bg_scroll_add (
	input  bg_types_pkg::coord_t    ly,
	input  bg_types_pkg::scroll_t   scy,
	input  bg_types_pkg::scroll_t   scx,
	bg_fetch_if.addr                fetch,
	output bg_types_pkg::tile_idx_t map_row,
	output bg_types_pkg::tile_idx_t map_col,
	output bg_types_pkg::fine_t     fine_y
);

	bg_types_pkg::coord_t bg_y;

	// Background wraps at 256 lines
	assign bg_y = ly + scy;
	assign map_row = bg_y[7:3];
	assign fine_y = bg_y[2:0];

	// Fine part of scx is handled by discarding pixels
	assign map_col = fetch.tile_col + scx[7:3];

endmodule

`default_nettype wire

// ==== verilog/bg_vram_addr.sv ====
`default_nettype none

module bg_vram_addr (
	bg_fetch_if.addr                fetch,
	input  bg_types_pkg::tile_idx_t map_row,
	input  bg_types_pkg::tile_idx_t map_col,
	input  bg_types_pkg::fine_t     fine_y,
	input  bg_types_pkg::vdata_t    tile_num,
	input  logic                    map_sel,
	input  logic                    data_unsigned,
	output bg_types_pkg::vaddr_t    vram_addr,
	output logic                    vram_rd
);

	bg_types_pkg::vaddr_t map_base;
	bg_types_pkg::vaddr_t map_addr;
	bg_types_pkg::vaddr_t data_base;
	bg_types_pkg::vaddr_t tile_ext;  // Tile number widened to address size
	bg_types_pkg::vaddr_t row_off;
	bg_types_pkg::vaddr_t data_addr;

	assign map_base = map_sel ? bg_map_pkg::MAP1_BASE : bg_map_pkg::MAP0_BASE;
	assign map_addr = map_base + bg_types_pkg::vaddr_t'(map_row) * bg_map_pkg::MAP_ROW_STRIDE +
		bg_types_pkg::vaddr_t'(map_col);

	always_comb begin
		if (data_unsigned) begin
			data_base = bg_map_pkg::DATA_UNSIGNED_BASE;
			tile_ext = {5'b00000, tile_num};
		end else begin
			data_base = bg_map_pkg::DATA_SIGNED_BASE;
			tile_ext = {{5{tile_num[7]}}, tile_num}; // -128..127 around the middle
		end
	end

	// Two bytes per row, high plane second
	assign row_off = {9'd0, fine_y, fetch.step == bg_types_pkg::DATA_HI};
	assign data_addr = data_base + tile_ext * bg_map_pkg::TILE_BYTES + row_off;

	assign vram_addr = (fetch.step == bg_types_pkg::MAP) ? map_addr : data_addr;
	assign vram_rd = fetch.rd;

endmodule

`default_nettype wire

// ==== verilog/bg_tile_latch.sv ====
`default_nettype none

module bg_tile_latch (
	input  logic                 clkpipe,
	input  logic                 rst_n,
	bg_fetch_if.data             fetch,
	input  bg_types_pkg::vdata_t vram_data,
	output bg_types_pkg::vdata_t tile_num,
	output bg_types_pkg::vdata_t plane_lo,
	output bg_types_pkg::vdata_t plane_hi
);

	// Step still names the read while its data arrives
	always_ff @(posedge clkpipe) begin
		if (!rst_n) begin
			tile_num <= '0;
			plane_lo <= '0;
			plane_hi <= '0;
		end else if (fetch.cap) begin
			case (fetch.step)
				bg_types_pkg::MAP:     tile_num <= vram_data;
				bg_types_pkg::DATA_LO: plane_lo <= vram_data;
				bg_types_pkg::DATA_HI: plane_hi <= vram_data;
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== verilog/bg_pixel_shift.sv ====
`default_nettype none

module bg_pixel_shift (
	input  logic                 clkpipe,
	input  logic                 rst_n,
	bg_fetch_if.data             fetch,
	input  bg_types_pkg::vdata_t plane_lo,
	input  bg_types_pkg::vdata_t plane_hi,
	input  logic                 bg_en,
	output bg_types_pkg::pix_t   pixel
);

	bg_types_pkg::vdata_t sh_lo;
	bg_types_pkg::vdata_t sh_hi;

	always_ff @(posedge clkpipe) begin
		if (!rst_n) begin
			sh_lo <= '0;
			sh_hi <= '0;
		end else if (fetch.push) begin // Load wins over shift
			sh_lo <= plane_lo;
			sh_hi <= plane_hi;
		end else if (fetch.shift) begin
			sh_lo <= {sh_lo[6:0], 1'b0};
			sh_hi <= {sh_hi[6:0], 1'b0};
		end
	end

	// Leftmost pixel sits in bit 7
	assign pixel = bg_en ? {sh_hi[7], sh_lo[7]} : 2'b00;

endmodule

`default_nettype wire

// ==== verilog/bg_pipe_top.sv ====
`default_nettype none

module bg_pipe_top (
	input  logic                  clkpipe,
	input  logic                  rst_n,
	input  logic                  line_start,
	input  bg_types_pkg::coord_t  ly,
	input  bg_types_pkg::scroll_t scy,
	input  bg_types_pkg::scroll_t scx,
	input  logic                  map_sel,
	input  logic                  data_unsigned,
	input  logic                  bg_en,
	output bg_types_pkg::vaddr_t  vram_addr,
	output logic                  vram_rd,
	input  bg_types_pkg::vdata_t  vram_data,
	output bg_types_pkg::pix_t    pixel,
	output logic                  pixel_valid,
	output logic                  line_done
);

	bg_types_pkg::tile_idx_t map_row;
	bg_types_pkg::tile_idx_t map_col;
	bg_types_pkg::fine_t     fine_y;
	bg_types_pkg::vdata_t    tile_num;
	bg_types_pkg::vdata_t    plane_lo;
	bg_types_pkg::vdata_t    plane_hi;

	bg_fetch_if fetch ();

	bg_fetch_ctrl u_ctrl (
		.clkpipe     (clkpipe),
		.rst_n       (rst_n),
		.line_start  (line_start),
		.scx         (scx),
		.fetch       (fetch.ctrl),
		.pixel_valid (pixel_valid),
		.line_done   (line_done)
	);

	bg_scroll_add u_scroll (
		.ly      (ly),
		.scy     (scy),
		.scx     (scx),
		.fetch   (fetch.addr),
		.map_row (map_row),
		.map_col (map_col),
		.fine_y  (fine_y)
	);

	bg_vram_addr u_addr (
		.fetch         (fetch.addr),
		.map_row       (map_row),
		.map_col       (map_col),
		.fine_y        (fine_y),
		.tile_num      (tile_num),
		.map_sel       (map_sel),
		.data_unsigned (data_unsigned),
		.vram_addr     (vram_addr),
		.vram_rd       (vram_rd)
	);

	bg_tile_latch u_latch (
		.clkpipe   (clkpipe),
		.rst_n     (rst_n),
		.fetch     (fetch.data),
		.vram_data (vram_data),
		.tile_num  (tile_num),
		.plane_lo  (plane_lo),
		.plane_hi  (plane_hi)
	);

	bg_pixel_shift u_shift (
		.clkpipe  (clkpipe),
		.rst_n    (rst_n),
		.fetch    (fetch.data),
		.plane_lo (plane_lo),
		.plane_hi (plane_hi),
		.bg_en    (bg_en),
		.pixel    (pixel)
	);

endmodule

`default_nettype wire

// ==== test/bg_clk_gen.sv ====
`default_nettype none

module bg_clk_gen (
	output logic clk
);

	initial clk = 1'b0;

	always #2 clk = ~clk; // Period 4

endmodule

`default_nettype wire

// ==== test/bg_chk.sv ====
`default_nettype none

module bg_chk (
	input logic                 clkpipe,
	input logic                 rst_n,
	input logic                 line_start,
	input logic                 vram_rd,
	input bg_types_pkg::vaddr_t vram_addr,
	input logic                 pixel_valid,
	input logic                 line_done
);

	logic       in_line; // Between line_start and line_done
	logic [1:0] rd_seq;  // Next read in the map, low, high triple

	always_ff @(posedge clkpipe) begin
		if (!rst_n) begin
			in_line <= 1'b0;
			rd_seq <= 2'd0;
		end else begin
			if (line_done)
				in_line <= 1'b0;
			else if (line_start)
				in_line <= 1'b1;
			if (line_start && !in_line)
				rd_seq <= 2'd0;
			else if (vram_rd)
				rd_seq <= (rd_seq == 2'd2) ? 2'd0 : rd_seq + 2'd1;
		end
	end

	a_rd_single: assert property (@(posedge clkpipe) disable iff (!rst_n)
		vram_rd |=> !vram_rd)
		else $error("vram_rd high on two consecutive cycles");

	a_pix_in_line: assert property (@(posedge clkpipe) disable iff (!rst_n)
		pixel_valid |-> in_line)
		else $error("pixel_valid high outside a line");

	a_done_pulse: assert property (@(posedge clkpipe) disable iff (!rst_n)
		line_done |=> !line_done)
		else $error("line_done longer than one cycle");

	// Map reads land in the map area, plane reads below it
	a_addr_range: assert property (@(posedge clkpipe) disable iff (!rst_n)
		vram_rd |-> ((rd_seq == 2'd0) == (vram_addr >= bg_map_pkg::MAP0_BASE)))
		else $error("vram_addr outside the area of its read");

endmodule

`default_nettype wire

// ==== test/bg_tb.sv ====
`default_nettype none

module bg_tb;

	localparam int VRAM_BYTES = 8192;
	localparam int NUM_LINES = 16;
	localparam int LINE_CYCLES = 400; // Budget per line for the watchdog

	logic                  clkpipe;
	logic                  rst_n;
	logic                  line_start;
	bg_types_pkg::coord_t  ly;
	bg_types_pkg::scroll_t scy;
	bg_types_pkg::scroll_t scx;
	logic                  map_sel;
	logic                  data_unsigned;
	logic                  bg_en;
	bg_types_pkg::vaddr_t  vram_addr;
	logic                  vram_rd;
	bg_types_pkg::vdata_t  vram_data = '0;
	bg_types_pkg::pix_t    pixel;
	logic                  pixel_valid;
	logic                  line_done;

	bg_types_pkg::vdata_t vram [0:VRAM_BYTES-1];
	string                test_name = "reset";
	logic                 active = 1'b0;
	logic                 prev_valid = 1'b0; // Strobe seen on the previous cycle
	int                   pix_count = 0;
	int                   lines_done = 0;

	bg_clk_gen u_clk (
		.clk (clkpipe)
	);

	bg_pipe_top DUT (
		.clkpipe       (clkpipe),
		.rst_n         (rst_n),
		.line_start    (line_start),
		.ly            (ly),
		.scy           (scy),
		.scx           (scx),
		.map_sel       (map_sel),
		.data_unsigned (data_unsigned),
		.bg_en         (bg_en),
		.vram_addr     (vram_addr),
		.vram_rd       (vram_rd),
		.vram_data     (vram_data),
		.pixel         (pixel),
		.pixel_valid   (pixel_valid),
		.line_done     (line_done)
	);

	bind bg_pipe_top bg_chk u_chk (
		.clkpipe     (clkpipe),
		.rst_n       (rst_n),
		.line_start  (line_start),
		.vram_rd     (vram_rd),
		.vram_addr   (vram_addr),
		.pixel_valid (pixel_valid),
		.line_done   (line_done)
	);

	// Read data one cycle after the strobe
	always @(posedge clkpipe) begin
		if (vram_rd)
			vram_data <= vram[vram_addr];
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Simulation finished: FAIL");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_value(input string name, input int expected, input int actual);
		if (expected !== actual)
			abort_run($sformatf("FAILED %s: expected %0d, actual %0d", name, expected, actual));
	endtask

	function automatic int ref_pixel(input int x, input int line, input int sx, input int sy,
		input logic msel, input logic dunsigned, input logic en);
		int   y;
		int   bx;
		int   map_addr;
		int   tile;
		int   row_addr;
		int   bit_pos;
		logic lo_bit;
		logic hi_bit;
		y = (line + sy) % 256;
		bx = (x + sx) % 256;
		map_addr = msel ? int'(bg_map_pkg::MAP1_BASE) : int'(bg_map_pkg::MAP0_BASE);
		map_addr = map_addr + (y / 8) * 32 + (bx / 8) % 32;
		tile = int'(vram[13'(map_addr)]);
		if (dunsigned) begin
			row_addr = int'(bg_map_pkg::DATA_UNSIGNED_BASE);
		end else begin
			row_addr = int'(bg_map_pkg::DATA_SIGNED_BASE);
			if (tile >= 128)
				tile = tile - 256;
		end
		row_addr = row_addr + tile * 16 + (y % 8) * 2;
		bit_pos = 7 - bx % 8; // Leftmost pixel in bit 7
		lo_bit = vram[13'(row_addr)][3'(bit_pos)];
		hi_bit = vram[13'(row_addr + 1)][3'(bit_pos)];
		return en ? int'({hi_bit, lo_bit}) : 0;
	endfunction

	task automatic run_line(input string name, input int line, input int sx, input int sy,
		input logic msel, input logic dunsigned, input logic en);
		int target;
		target = lines_done + 1;
		test_name = name;
		@(posedge clkpipe);
		ly <= 8'(line);
		scx <= 8'(sx);
		scy <= 8'(sy);
		map_sel <= msel;
		data_unsigned <= dunsigned;
		bg_en <= en;
		line_start <= 1'b1;
		@(posedge clkpipe);
		line_start <= 1'b0;
		while (lines_done < target)
			@(posedge clkpipe);
		repeat (3) @(posedge clkpipe); // Idle gap, no strobes allowed
	endtask

	// Outputs settle well before the falling edge
	always @(negedge clkpipe) begin
		if (rst_n) begin
			if (line_start && !active) begin
				active = 1'b1;
				pix_count = 0;
			end
			if (pixel_valid) begin
				if (!active) begin
					abort_run("ERROR: pixel_valid strobe outside a line");
				end else begin
					check_value($sformatf("%s ly=%0d x=%0d", test_name, ly, pix_count),
						ref_pixel(pix_count, int'(ly), int'(scx), int'(scy), map_sel,
						data_unsigned, bg_en), int'(pixel));
					pix_count++;
				end
			end
			if (line_done) begin
				if (!active) begin
					abort_run("ERROR: line_done pulse outside a line");
				end else begin
					if (!prev_valid)
						abort_run("ERROR: line_done not one cycle after the last pixel");
					check_value({test_name, " pixel count"}, bg_map_pkg::LINE_PIXELS, pix_count);
					active = 1'b0;
					lines_done++;
				end
			end
			prev_valid = pixel_valid;
		end
	end

	initial begin
		repeat (LINE_CYCLES * NUM_LINES + 20) @(posedge clkpipe);
		abort_run("ERROR: watchdog expired before all lines completed");
	end

	initial begin
		int i;
		int k;
		int ln;
		int sx;
		int sy;
		void'($urandom(32));
		rst_n = 1'b0;
		line_start = 1'b0;
		ly = '0;
		scy = '0;
		scx = '0;
		map_sel = 1'b0;
		data_unsigned = 1'b1;
		bg_en = 1'b1;
		for (i = 0; i < VRAM_BYTES; i++)
			vram[13'(i)] = 8'($urandom);
		repeat (2) @(posedge clkpipe);
		rst_n <= 1'b1;
		@(posedge clkpipe);

		run_line("zero scroll", 0, 0, 0, 1'b0, 1'b1, 1'b1);
		run_line("zero scroll", 5, 0, 0, 1'b0, 1'b1, 1'b1);
		run_line("zero scroll", 8, 0, 0, 1'b0, 1'b1, 1'b1);
		run_line("zero scroll", 143, 0, 0, 1'b0, 1'b1, 1'b1);

		// Both sums wrap, column passes 31
		run_line("scroll wrap", 100, 250, 200, 1'b0, 1'b1, 1'b1);
		run_line("scroll wrap", 143, 255, 255, 1'b0, 1'b1, 1'b1);
		for (k = 0; k < 4; k++) begin
			ln = int'($urandom_range(143));
			sx = int'($urandom_range(255));
			sy = int'($urandom_range(255));
			run_line("random scroll", ln, sx, sy, 1'b0, 1'b1, 1'b1);
		end

		run_line("signed data", 0, 0, 0, 1'b0, 1'b0, 1'b1);
		run_line("signed data", 77, 13, 90, 1'b0, 1'b0, 1'b1);
		run_line("signed data", 140, 203, 180, 1'b0, 1'b0, 1'b1);

		run_line("second map", 30, 6, 0, 1'b1, 1'b1, 1'b1);
		run_line("second map", 120, 140, 100, 1'b1, 1'b0, 1'b1);

		run_line("bg disabled", 60, 3, 20, 1'b0, 1'b1, 1'b0);

		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

`default_nettype wire

// ==== all.f ====
verilog/bg_types_pkg.sv
verilog/bg_map_pkg.sv
verilog/bg_fetch_if.sv
verilog/bg_fetch_ctrl.sv
verilog/bg_scroll_add.sv
verilog/bg_vram_addr.sv
verilog/bg_tile_latch.sv
verilog/bg_pixel_shift.sv
verilog/bg_pipe_top.sv
test/bg_clk_gen.sv
test/bg_chk.sv
test/bg_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the background pipe testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f all.f --top-module bg_tb -o bg_sim

output=$(./obj_dir/bg_sim 2>&1) || true
echo "$output"

echo "$output" | grep -q "^Simulation finished: PASS$"
echo "run_sim: simulation passed"
